/* filelist.f */
sfu_pkg.sv
psum_abs_sum.sv
sfu_fifo.sv
sfu_norm.sv
sfu.sv
sfu_checker.sv
tb_sfu.sv

/* Makefile */
# sfu testbench under Verilator
# make test builds and runs it, make clean removes the build

TOP := tb_sfu

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module $(TOP) -f filelist.f -o V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
		echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

/* tb_sfu.sv */
//****************************************
// sfu testbench, table of words with peer sums and sink stalls
// top module tb_sfu, results compared by sfu_checker
//****************************************
`timescale 1ns/1ns

module tb_sfu;

  import sfu_pkg::*;

  localparam int num_rows = 24;
  localparam int bp_words = 20;
  localparam int total_words = num_rows + bp_words;
  localparam int clk_period = 100;
  // generous budget per word, covers random stalls
  localparam int watchdog_cycles = total_words * 40;

  // one table row
  // stall bit 0 out_ready gaps, bit 1 local_ready gaps, bit 2 peer gaps
  typedef struct packed {
    psum_vec_t        psum;
    logic             sign;
    logic [sum_w-1:0] peer;
    logic [2:0]       stall;
  } vec_row_t;

  logic clk = 1'b0;
  logic rst_n;

  // DUT ports
  psum_vec_t        psum_in;
  logic             in_valid;
  logic             in_ready;
  logic             sign_mode;
  logic [sum_w-1:0] peer_sum = '0;
  logic             peer_valid = 1'b0;
  logic             peer_ready;
  logic [sum_w-1:0] local_sum;
  logic             local_valid;
  logic             local_ready = 1'b0;
  norm_result_t     norm_out;
  logic             out_valid;
  logic             out_ready = 1'b0;

  // side channel to the checker
  logic bp_check;
  int   bp_count;
  logic end_check;
  int   results;
  int   errors;

  // stimulus state
  vec_row_t         tbl [num_rows];
  logic [sum_w-1:0] peer_q [$];
  logic [2:0]       stall_mode;
  logic             hold_out;
  logic             peer_hs;
  int               sent;
  int               accepted;
  int               idle;

  always #(clk_period/2) clk = ~clk;

  sfu dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .psum_in     (psum_in),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .sign_mode   (sign_mode),
    .peer_sum    (peer_sum),
    .peer_valid  (peer_valid),
    .peer_ready  (peer_ready),
    .local_sum   (local_sum),
    .local_valid (local_valid),
    .local_ready (local_ready),
    .norm_out    (norm_out),
    .out_valid   (out_valid),
    .out_ready   (out_ready)
  );

  sfu_checker chk (.*);

  // peer handshake seen at the last rising edge
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      peer_hs <= 1'b0;
    end else begin
      peer_hs <= peer_valid && peer_ready;
    end
  end

  // sink stalls and peer source, one process so the random draws keep their order
  always @(negedge clk) begin
    if (rst_n) begin
      if (hold_out) begin
        out_ready = 1'b0;
      end else if (stall_mode[0]) begin
        out_ready = ($urandom % 4) != 0;
      end else begin
        out_ready = 1'b1;
      end
      if (stall_mode[1]) begin
        local_ready = ($urandom % 4) != 0;
      end else begin
        local_ready = 1'b1;
      end
      // one peer sum per accepted word, in order
      if (peer_hs) begin
        peer_valid = 1'b0;
      end
      if (!peer_valid && peer_q.size() > 0) begin
        if (!stall_mode[2] || ($urandom % 3) != 0) begin
          peer_sum   = peer_q.pop_front();
          peer_valid = 1'b1;
        end
      end
    end
  end

  // column 7 is the leftmost group of each literal
  task automatic load_table();
    // signed, negative columns
    tbl[0]  = '{96'hfff_ffe_001_002_800_7ff_010_f00, 1'b1, 16'h0100, 3'd0};
    tbl[1]  = '{96'h801_123_fed_004_0ff_f80_700_050, 1'b1, 16'h0000, 3'd0};
    tbl[2]  = '{96'h800_800_800_800_800_800_800_800, 1'b1, 16'h4000, 3'd1};
    tbl[3]  = '{96'hf01_f02_f03_f04_f05_f06_f07_f08, 1'b1, 16'h0123, 3'd3};
    tbl[4]  = '{96'h001_002_003_004_005_006_007_008, 1'b1, 16'h0024, 3'd0};
    tbl[5]  = '{96'hfff_fff_fff_fff_fff_fff_fff_fff, 1'b1, 16'h0008, 3'd2};
    // unsigned, top bits taken as plain value
    tbl[6]  = '{96'hfff_ffe_001_002_800_7ff_010_f00, 1'b0, 16'h0100, 3'd0};
    tbl[7]  = '{96'h800_800_800_800_800_800_800_800, 1'b0, 16'h4000, 3'd1};
    tbl[8]  = '{96'hfff_fff_fff_fff_fff_fff_fff_fff, 1'b0, 16'hffff, 3'd3};
    tbl[9]  = '{96'h123_456_789_abc_def_012_345_678, 1'b0, 16'h1000, 3'd2};
    tbl[10] = '{96'h0a0_0b0_0c0_0d0_0e0_0f0_100_110, 1'b0, 16'h0000, 3'd0};
    tbl[11] = '{96'h7ff_000_7ff_000_7ff_000_7ff_000, 1'b0, 16'h0001, 3'd4};
    // zero totals and lone columns that wrap
    tbl[12] = '{96'h000_000_000_000_000_000_000_000, 1'b0, 16'h0000, 3'd0};
    tbl[13] = '{96'h000_000_000_000_000_000_000_000, 1'b1, 16'h0000, 3'd0};
    tbl[14] = '{96'h000_000_000_000_000_000_000_005, 1'b0, 16'h0000, 3'd0};
    tbl[15] = '{96'h000_000_000_ffb_000_000_000_000, 1'b1, 16'h0000, 3'd0};
    tbl[16] = '{96'h000_000_000_000_000_000_000_000, 1'b0, 16'h0010, 3'd0};
    tbl[17] = '{96'h800_000_000_000_000_000_000_000, 1'b1, 16'h0000, 3'd0};
    // mixed traffic under stalls
    tbl[18] = '{96'h3c0_c40_5a5_a5a_0f0_f0f_111_eee, 1'b1, 16'h0200, 3'd7};
    tbl[19] = '{96'h3c0_c40_5a5_a5a_0f0_f0f_111_eee, 1'b0, 16'h0200, 3'd7};
    tbl[20] = '{96'h010_020_030_040_050_060_070_080, 1'b0, 16'h0010, 3'd5};
    tbl[21] = '{96'hff0_fe0_fd0_fc0_fb0_fa0_f90_f80, 1'b1, 16'h0800, 3'd6};
    tbl[22] = '{96'h001_000_000_000_000_000_000_001, 1'b0, 16'hfffe, 3'd7};
    tbl[23] = '{96'h7ff_7ff_7ff_7ff_7ff_7ff_7ff_7ff, 1'b1, 16'h0003, 3'd1};
  endtask

  // offer one word, return at the edge that took it
  task automatic send_word(input vec_row_t row);
    stall_mode = row.stall;
    @(negedge clk);
    psum_in   = row.psum;
    sign_mode = row.sign;
    in_valid  = 1'b1;
    @(posedge clk);
    while (!in_ready) begin
      @(posedge clk);
    end
    peer_q.push_back(row.peer);
    sent++;
  endtask

  task automatic stop_input();
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  // every result and every local sum out
  task automatic wait_drain();
    while (results < sent || local_valid) begin
      @(negedge clk);
    end
  endtask

  // sink held off, count words taken before in_ready drops
  task automatic run_backpressure();
    vec_row_t row;
    @(posedge clk);
    hold_out   = 1'b1;
    stall_mode = '0;
    accepted   = 0;
    idle       = 0;
    @(negedge clk);
    psum_in   = tbl[0].psum;
    sign_mode = tbl[0].sign;
    in_valid  = 1'b1;
    while (idle < 4) begin
      @(posedge clk);
      if (in_ready) begin
        peer_q.push_back(tbl[accepted % num_rows].peer);
        accepted++;
        sent++;
        idle = 0;
        @(negedge clk);
        psum_in   = tbl[accepted % num_rows].psum;
        sign_mode = tbl[accepted % num_rows].sign;
      end else begin
        idle++;
      end
    end
    @(negedge clk);
    bp_count = accepted;
    bp_check = 1'b1;
    @(negedge clk);
    bp_check = 1'b0;
    @(posedge clk);
    hold_out = 1'b0;
    // rest of the burst with the sink open
    for (int i = accepted; i < bp_words; i++) begin
      row       = tbl[i % num_rows];
      row.stall = '0;
      send_word(row);
    end
  endtask

  initial begin
    void'($urandom(9));
    rst_n      = 1'b0;
    psum_in    = '0;
    in_valid   = 1'b0;
    sign_mode  = 1'b0;
    bp_check   = 1'b0;
    bp_count   = 0;
    end_check  = 1'b0;
    stall_mode = '0;
    hold_out   = 1'b0;
    sent       = 0;
    accepted   = 0;
    idle       = 0;
    load_table();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // a few idle cycles in the reset state
    repeat (3) @(posedge clk);
    for (int r = 0; r < num_rows; r++) begin
      send_word(tbl[r]);
    end
    stop_input();
    wait_drain();
    run_backpressure();
    stop_input();
    wait_drain();
    end_check = 1'b1;
    @(negedge clk);
    end_check = 1'b0;
    @(negedge clk);
    $display("summary: %0d of %0d results checked, %0d errors", results, total_words, errors);
    if (errors == 0 && results == total_words) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(watchdog_cycles * clk_period);
    $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* sfu_checker.sv */
//****************************************
// sfu result checker, models the queues from the handshakes
// instance inside tb_sfu, reports one line per result
//****************************************
`timescale 1ns/1ns

module sfu_checker (
  input  logic                      clk,
  input  logic                      rst_n,
  input  sfu_pkg::psum_vec_t        psum_in,
  input  logic                      in_valid,
  input  logic                      in_ready,
  input  logic                      sign_mode,
  input  logic [sfu_pkg::sum_w-1:0] peer_sum,
  input  logic                      peer_valid,
  input  logic                      peer_ready,
  input  logic [sfu_pkg::sum_w-1:0] local_sum,
  input  logic                      local_valid,
  input  logic                      local_ready,
  input  sfu_pkg::norm_result_t     norm_out,
  input  logic                      out_valid,
  input  logic                      out_ready,
  input  logic                      bp_check,
  input  int                        bp_count,
  input  logic                      end_check,
  output int                        results,
  output int                        errors
);

  import sfu_pkg::*;

  // expected traffic, oldest first
  psum_vec_t        exp_mag_q [$];
  logic [sum_w-1:0] exp_sum_q [$];
  logic [sum_w-1:0] exp_local_q [$];
  logic [sum_w-1:0] exp_peer_q [$];
  // words waiting for a peer sum, and words waiting to leave for the peer
  int               entry_cnt;
  int               link_cnt;
  logic             out_full;

  // negative column in signed mode counts as its distance from zero
  function automatic logic [psum_w-1:0] magnitude(input logic [psum_w-1:0] v,
                                                  input logic signed_mode);
    if (signed_mode && v[psum_w-1]) begin
      return psum_w'((1 << psum_w) - int'(v));
    end
    return v;
  endfunction

  task automatic check_hex(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("FAIL %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  always @(posedge clk) begin
    psum_vec_t        mag;
    logic [sum_w-1:0] lsum;
    int               sum;
    int               total;
    int               quot;
    int               bad;
    if (!rst_n) begin
      exp_mag_q.delete();
      exp_sum_q.delete();
      exp_local_q.delete();
      exp_peer_q.delete();
      entry_cnt = 0;
      link_cnt  = 0;
      out_full  = 1'b0;
      results   = 0;
      errors    = 0;
    end else begin
      // handshake outputs against the queue model, also covers the reset state
      check_hex("in_ready", int'(in_ready),
                int'(entry_cnt < fifo_depth && link_cnt < fifo_depth));
      check_hex("local_valid", int'(local_valid), int'(link_cnt != 0));
      check_hex("out_valid", int'(out_valid), int'(out_full));
      check_hex("peer_ready", int'(peer_ready),
                int'(entry_cnt != 0 && peer_valid && (!out_full || out_ready)));
      if (in_valid && in_ready) begin
        sum = 0;
        for (int c = 0; c < num_col; c++) begin
          mag[c] = magnitude(psum_in[c], sign_mode);
          sum += int'(mag[c]);
        end
        exp_mag_q.push_back(mag);
        exp_sum_q.push_back(sum_w'(sum));
        exp_local_q.push_back(sum_w'(sum));
      end
      if (peer_valid && peer_ready) begin
        exp_peer_q.push_back(peer_sum);
      end
      // local sums leave in input order
      if (local_valid && local_ready) begin
        if (exp_local_q.size() == 0) begin
          $display("local_sum handed over with no word accepted");
          errors++;
        end else begin
          lsum = exp_local_q.pop_front();
          check_hex("local_sum", int'(local_sum), int'(lsum));
        end
      end
      if (out_valid && out_ready) begin
        if (exp_mag_q.size() == 0 || exp_peer_q.size() == 0) begin
          $display("result came out with no matching word and peer sum");
          errors++;
        end else begin
          bad   = errors;
          mag   = exp_mag_q.pop_front();
          sum   = int'(exp_sum_q.pop_front());
          total = sum + int'(exp_peer_q.pop_front());
          check_hex("total", int'(norm_out.total), total);
          for (int c = 0; c < num_col; c++) begin
            // scaled magnitude over the two-core total, low 12 bits kept
            quot = (total == 0) ? 0 : ((int'(mag[c]) << frac_shift) / total) % (1 << psum_w);
            check_hex($sformatf("quot[%0d]", c), int'(norm_out.quot[c]), quot);
          end
          if (errors == bad) begin
            $display("result %0d ok, total %h", results, total);
          end else begin
            $display("result %0d done with %0d mismatches", results, errors - bad);
          end
        end
        results++;
      end
      // burst while the sink is held off
      if (bp_check) begin
        check_hex("words accepted before in_ready fell", bp_count, fifo_depth + 1);
        $display("backpressure: in_ready fell after %0d accepted words", bp_count);
      end
      if (end_check && (exp_mag_q.size() != 0 || exp_local_q.size() != 0)) begin
        $display("%0d results and %0d local sums never came out",
                 exp_mag_q.size(), exp_local_q.size());
        errors++;
      end
      // model update after the checks of this edge
      if (in_valid && in_ready) begin
        entry_cnt++;
        link_cnt++;
      end
      if (peer_valid && peer_ready) begin
        entry_cnt--;
        out_full = 1'b1;
      end else if (out_ready) begin
        out_full = 1'b0;
      end
      if (local_valid && local_ready) begin
        link_cnt--;
      end
    end
  end

endmodule

/* sfu.sv */
//****************************************
// sfu top, input stage, entry and peer FIFOs, normalizer
//****************************************
`timescale 1ns/1ns

module sfu (
  input  logic                      clk,
  input  logic                      rst_n,
  // partial sums from the array
  input  sfu_pkg::psum_vec_t        psum_in,
  input  logic                      in_valid,
  output logic                      in_ready,
  input  logic                      sign_mode,
  // sum arriving from the other core
  input  logic [sfu_pkg::sum_w-1:0] peer_sum,
  input  logic                      peer_valid,
  output logic                      peer_ready,
  // sum leaving for the other core
  output logic [sfu_pkg::sum_w-1:0] local_sum,
  output logic                      local_valid,
  input  logic                      local_ready,
  // normalized result
  output sfu_pkg::norm_result_t     norm_out,
  output logic                      out_valid,
  input  logic                      out_ready
);

  import sfu_pkg::*;

  psum_vec_t        mag;
  logic [sum_w-1:0] mag_sum;
  logic             in_fire;
  sfu_entry_t       entry_in;
  sfu_entry_t       entry_head;
  logic             entry_full;
  logic             entry_empty;
  logic             entry_pop;
  logic             peer_full;
  logic             peer_empty;

  // take a word only when both queues have room
  assign in_ready = !entry_full && !peer_full;
  assign in_fire  = in_valid && in_ready;

  // sign_mode sampled with the word through the combinational stage
  psum_abs_sum u_abs (
    .psum      (psum_in),
    .sign_mode (sign_mode),
    .mag       (mag),
    .sum       (mag_sum)
  );

  assign entry_in.mag = mag;
  assign entry_in.sum = mag_sum;

  // magnitudes and local sum, waiting for the peer sum
  sfu_fifo #(.width($bits(sfu_entry_t))) entry_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (in_fire),
    .wr_data (entry_in),
    .rd_en   (entry_pop),
    .rd_data (entry_head),
    .full    (entry_full),
    .empty   (entry_empty)
  );

  // local sums for the other core, drained on its own handshake
  sfu_fifo #(.width(sum_w)) peer_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (in_fire),
    .wr_data (mag_sum),
    .rd_en   (local_valid && local_ready),
    .rd_data (local_sum),
    .full    (peer_full),
    .empty   (peer_empty)
  );

  assign local_valid = !peer_empty;

  sfu_norm u_norm (
    .clk         (clk),
    .rst_n       (rst_n),
    .entry       (entry_head),
    .entry_valid (!entry_empty),
    .entry_pop   (entry_pop),
    .peer_sum    (peer_sum),
    .peer_valid  (peer_valid),
    .peer_ready  (peer_ready),
    .norm_out    (norm_out),
    .out_valid   (out_valid),
    .out_ready   (out_ready)
  );

endmodule

/* sfu_norm.sv */
//****************************************
// joins queued entry with the peer sum, registers eight quotients
//****************************************
`timescale 1ns/1ns

module sfu_norm (
  input  logic                      clk,
  input  logic                      rst_n,
  input  sfu_pkg::sfu_entry_t       entry,
  input  logic                      entry_valid,
  output logic                      entry_pop,
  input  logic [sfu_pkg::sum_w-1:0] peer_sum,
  input  logic                      peer_valid,
  output logic                      peer_ready,
  output sfu_pkg::norm_result_t     norm_out,
  output logic                      out_valid,
  input  logic                      out_ready
);

  import sfu_pkg::*;

  logic               fire;
  logic [total_w-1:0] total_sum;
  logic [div_w-1:0]   dividend;
  logic [div_w-1:0]   divisor;
  norm_result_t       norm_nxt;

  // three-way join: entry queued, peer sum present, output slot free
  // slot counts as free when the sink drains it this cycle
  assign fire = entry_valid && peer_valid && (!out_valid || out_ready);

  // both sources are consumed together
  assign entry_pop  = fire;
  assign peer_ready = fire;

  // two-core total, carry kept
  assign total_sum = {1'b0, entry.sum} + {1'b0, peer_sum};

  // per column (mag << frac_shift) / total
  always_comb begin
    divisor        = div_w'(total_sum);
    norm_nxt.total = total_sum;
    for (int c = 0; c < num_col; c++) begin
      dividend = {entry.mag[c], {frac_shift{1'b0}}};
      // zero total gives zero quotients, no divide by zero
      if (total_sum == '0) begin
        norm_nxt.quot[c] = '0;
      end else begin
        // only the low psum_w bits survive, a lone column wraps to 0
        norm_nxt.quot[c] = psum_w'(dividend / divisor);
      end
    end
  end

  // output payload
  always_ff @(posedge clk) begin
    if (fire) begin
      norm_out <= norm_nxt;
    end
  end

  // output valid flag
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (fire) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // stalled result must hold until the sink takes it
  assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(norm_out))
    else $error("norm_out changed while stalled");

endmodule

/* sfu_fifo.sv */
//****************************************
// show-ahead FIFO, head visible while not empty
//****************************************
`timescale 1ns/1ns

module sfu_fifo #(
  parameter int width = 16
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             wr_en,
  input  logic [width-1:0] wr_data,
  input  logic             rd_en,
  output logic [width-1:0] rd_data,
  output logic             full,
  output logic             empty
);

  import sfu_pkg::*;

  // storage
  logic [width-1:0] mem [fifo_depth];

  // pointers wrap on their own, depth is a power of two
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  // one extra bit so a full queue is distinct from empty
  logic [ptr_w:0]   count;

  // flags straight from the count
  assign full  = (count == (ptr_w+1)'(fifo_depth));
  assign empty = (count == '0);

  // head of queue, valid only while not empty
  assign rd_data = mem[rd_ptr];

  // data array, written on every push
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // pointer and occupancy tracking
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // push and pop together leave the count alone
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // caller must watch full before pushing
  assert property (@(posedge clk) disable iff (!rst_n) !(wr_en && full))
    else $error("fifo write while full");

  // caller must watch empty before popping
  assert property (@(posedge clk) disable iff (!rst_n) !(rd_en && empty))
    else $error("fifo read while empty");

endmodule

/* psum_abs_sum.sv */
//****************************************
// column magnitudes and their local sum
//****************************************
`timescale 1ns/1ns

module psum_abs_sum (
  input  sfu_pkg::psum_vec_t       psum,
  input  logic                     sign_mode,
  output sfu_pkg::psum_vec_t       mag,
  output logic [sfu_pkg::sum_w-1:0] sum
);

  import sfu_pkg::*;

  // adder tree stages, one bit wider per level
  logic [psum_w:0]   pair_sum [num_col/2];
  logic [psum_w+1:0] quad_sum [num_col/4];

  // sign handling per column
  always_comb begin
    for (int c = 0; c < num_col; c++) begin
      // negative column in signed mode, flip to two's complement magnitude
      // note -2048 maps to 0x800, read as unsigned 2048
      if (sign_mode && psum[c][psum_w-1]) begin
        mag[c] = ~psum[c] + 1'b1;
      end else begin
        mag[c] = psum[c];
      end
    end
  end

  // first level, neighbouring columns
  always_comb begin
    for (int p = 0; p < num_col/2; p++) begin
      pair_sum[p] = {1'b0, mag[2*p]} + {1'b0, mag[2*p+1]};
    end
  end

  // second level
  always_comb begin
    for (int q = 0; q < num_col/4; q++) begin
      quad_sum[q] = {1'b0, pair_sum[2*q]} + {1'b0, pair_sum[2*q+1]};
    end
  end

  // last level, zero-extended into the local sum
  assign sum = sum_w'(quad_sum[0]) + sum_w'(quad_sum[1]);

endmodule

/* sfu_pkg.sv */
//****************************************
// widths, depths and stream types shared by the sfu blocks
// import inside each module body that needs them
//****************************************
package sfu_pkg;

  // column geometry of one input word
  localparam int num_col = 8;
  localparam int psum_w = 12;

  // eight 12-bit magnitudes fit in 15 bits, one spare bit kept
  localparam int sum_w = psum_w + 4;

  // local sum plus peer sum, one carry bit
  localparam int total_w = sum_w + 1;

  // magnitude is scaled up before the divide
  localparam int frac_shift = 12;
  localparam int div_w = psum_w + frac_shift;

  // both queues share one depth
  localparam int fifo_depth = 16;
  localparam int ptr_w = $clog2(fifo_depth);

  // eight columns, column 0 in the low bits
  typedef logic [num_col-1:0][psum_w-1:0] psum_vec_t;

  // one queued word: magnitudes and their local sum
  typedef struct packed {
    psum_vec_t        mag;
    logic [sum_w-1:0] sum;
  } sfu_entry_t;

  // one normalized word plus the divisor it used
  typedef struct packed {
    psum_vec_t          quot;
    logic [total_w-1:0] total;
  } norm_result_t;

endpackage
